//--- common/na_pkg.sv
package na_pkg;

   localparam int FLIT_WIDTH = 32;   // NoC link
   localparam int BUS_WIDTH  = 32;   // Wishbone data and address

   // Packet class of message passing traffic
   localparam logic [2:0] CLASS_MP = 3'd0;

   // Slave select, address bits 23:20
   localparam logic [3:0] REGION_CONF = 4'd0;
   localparam logic [3:0] REGION_MP   = 4'd1;

   // Byte offsets inside the configuration region
   localparam logic [5:0] CONF_TILEID   = 6'h00;
   localparam logic [5:0] CONF_COREBASE = 6'h04;
   localparam logic [5:0] CONF_DROPPED  = 6'h08;
   localparam logic [5:0] CONF_CTRL     = 6'h0c;   // Bit 0 enables the interrupt

   // Byte offsets inside the message buffer region
   localparam logic [5:0] MP_DATA   = 6'h00;
   localparam logic [5:0] MP_STATUS = 6'h04;

   typedef struct packed {
      logic [4:0]  dest;
      logic [2:0]  pkt_class;
      logic [4:0]  src;
      logic [18:0] rest;
   } flit_hdr_t;

   // Header view on the first flit, raw word on the others
   typedef union packed {
      flit_hdr_t             hdr;
      logic [FLIT_WIDTH-1:0] data;
   } flit_u;

   typedef struct packed {
      flit_u flit;
      logic  last;
   } noc_link_t;

   typedef struct packed {
      logic                 cyc;
      logic                 stb;
      logic                 we;
      logic [BUS_WIDTH-1:0] adr;
      logic [BUS_WIDTH-1:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic                 ack;
      logic                 err;
      logic [BUS_WIDTH-1:0] dat;
   } wb_rsp_t;

   typedef struct packed {
      logic                 stb;      // One cycle per bus access
      logic                 we;
      logic [3:0]           offset;   // Word offset
      logic [BUS_WIDTH-1:0] dat;
   } slv_req_t;

   typedef logic [BUS_WIDTH-1:0] slv_rsp_t;

endpackage

//--- filelist.f
common/na_pkg.sv
verilog/noc_flit_fifo.sv
verilog/wb_slave_decode.sv
verilog/na_conf.sv
mpbuffer/mp_send.sv
mpbuffer/mp_recv.sv
verilog/na_compute_tile.sv
tests/tb_na_compute_tile.sv

//--- mpbuffer/mp_recv.sv
`timescale 1ns/1ps

module mp_recv #(
   parameter int DEPTH = 16
) (
   input  logic              clk,
   input  logic              reset_i,
   input  na_pkg::noc_link_t in_i,
   input  logic              in_valid_i,
   output logic              in_ready_o,
   input  na_pkg::slv_req_t  req_i,
   output na_pkg::slv_rsp_t  rsp_o,
   input  logic              overflow_i,
   input  logic              irq_en_i,
   output logic              drop_o,
   output logic              irq_o
);

   logic                         in_pkt_q;   // Inside a packet
   logic                         drop_q;     // Current packet is discarded
   logic [na_pkg::BUS_WIDTH-1:0] cnt_q;
   logic                         cur_drop;
   logic                         xfer;
   logic                         store;
   na_pkg::noc_link_t            sz_in;
   na_pkg::noc_link_t            sz_out;
   na_pkg::noc_link_t            st_out;
   logic                         st_ready;
   logic                         st_valid;
   logic                         sz_ready;
   logic                         sz_valid;
   logic                         reading_q;
   logic [5:0]                   addr;
   logic                         data_rd;
   logic                         rd_size;
   logic                         rd_flit;

   // The header flit decides for the whole packet
   assign cur_drop = in_pkt_q ? drop_q
                              : (in_i.flit.hdr.pkt_class != na_pkg::CLASS_MP);

   assign in_ready_o = cur_drop | (st_ready & sz_ready);   // Drops never stall
   assign xfer       = in_valid_i & in_ready_o;
   assign store      = xfer & ~cur_drop;
   assign drop_o     = xfer & cur_drop & in_i.last;

   always_comb begin
      sz_in.flit.data = cnt_q + 1'b1;   // Includes the last flit
      sz_in.last      = 1'b0;
   end

   // Packets longer than DEPTH never complete and block the input
   noc_flit_fifo #(
      .DEPTH(DEPTH)
   ) u_store (
      .clk         (clk),
      .reset_i     (reset_i),
      .in_i        (in_i),
      .in_valid_i  (store),
      .in_ready_o  (st_ready),
      .out_o       (st_out),
      .out_valid_o (st_valid),
      .out_ready_i (rd_flit)
   );

   noc_flit_fifo #(
      .DEPTH(DEPTH)
   ) u_sizes (
      .clk         (clk),
      .reset_i     (reset_i),
      .in_i        (sz_in),
      .in_valid_i  (store & in_i.last),
      .in_ready_o  (sz_ready),
      .out_o       (sz_out),
      .out_valid_o (sz_valid),
      .out_ready_i (rd_size)
   );

   always_ff @(posedge clk) begin
      if (reset_i) begin
         in_pkt_q <= 1'b0;
         drop_q   <= 1'b0;
         cnt_q    <= '0;
      end else if (xfer) begin
         in_pkt_q <= ~in_i.last;
         drop_q   <= cur_drop;
         if (in_i.last)
            cnt_q <= '0;
         else if (!cur_drop)
            cnt_q <= cnt_q + 1'b1;
      end
   end

   assign addr    = {req_i.offset, 2'b00};
   assign data_rd = req_i.stb & ~req_i.we & (addr == na_pkg::MP_DATA);
   assign rd_size = data_rd & ~reading_q;
   assign rd_flit = data_rd & reading_q;

   // Size first, then the flits up to last
   always_ff @(posedge clk) begin
      if (reset_i)
         reading_q <= 1'b0;
      else if (rd_size && sz_valid)
         reading_q <= 1'b1;
      else if (rd_flit && st_valid && st_out.last)
         reading_q <= 1'b0;
   end

   always_comb begin
      case (addr)
         na_pkg::MP_DATA:
            rsp_o = reading_q ? st_out.flit.data : (sz_valid ? sz_out.flit.data : '0);
         na_pkg::MP_STATUS:
            rsp_o = {{(na_pkg::BUS_WIDTH - 2){1'b0}}, overflow_i, sz_valid};
         default:
            rsp_o = '0;
      endcase
   end

   assign irq_o = sz_valid & irq_en_i;

   // Size is only queued once every flit is stored
   a_flit_present: assert property (@(posedge clk) disable iff (reset_i)
      rd_flit |-> st_valid);

endmodule

//--- mpbuffer/mp_send.sv
`timescale 1ns/1ps

module mp_send #(
   parameter int DEPTH = 16
) (
   input  logic              clk,
   input  logic              reset_i,
   input  na_pkg::slv_req_t  req_i,
   output na_pkg::noc_link_t out_o,
   output logic              out_valid_o,
   input  logic              out_ready_i,
   output logic              overflow_o
);

   logic [na_pkg::BUS_WIDTH-1:0] rem_q;   // Flits still expected in this packet
   logic                         data_wr;
   logic                         push;
   logic                         q_ready;
   logic                         overflow_q;
   na_pkg::noc_link_t            q_in;

   assign data_wr = req_i.stb & req_i.we & ({req_i.offset, 2'b00} == na_pkg::MP_DATA);
   assign push    = data_wr & (rem_q != '0);

   always_comb begin
      q_in.flit.data = req_i.dat;
      q_in.last      = (rem_q == na_pkg::BUS_WIDTH'(1));
   end

   // Send queue, drained by the output link buffer
   noc_flit_fifo #(
      .DEPTH(DEPTH)
   ) u_queue (
      .clk         (clk),
      .reset_i     (reset_i),
      .in_i        (q_in),
      .in_valid_i  (push),
      .in_ready_o  (q_ready),
      .out_o       (out_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i)
   );

   always_ff @(posedge clk) begin
      if (reset_i) begin
         rem_q      <= '0;
         overflow_q <= 1'b0;
      end else begin
         if (data_wr) begin
            if (rem_q == '0)
               rem_q <= req_i.dat;   // Size word, zero keeps idle
            else
               rem_q <= rem_q - 1'b1;
         end
         // Write acks anyway and the flit is gone
         if (push && !q_ready)
            overflow_q <= 1'b1;
      end
   end

   assign overflow_o = overflow_q;

   // Inside a packet the count only steps down by one
   a_rem_no_wrap: assert property (@(posedge clk) disable iff (reset_i)
      rem_q != '0 |=> rem_q == $past(rem_q) || rem_q == $past(rem_q) - 1'b1);

endmodule

//--- run_sim.sh
#!/bin/sh
# Run from the project root
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
   --top-module tb_na_compute_tile -o tb_na_compute_tile > build.log 2>&1 ||
   { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tb_na_compute_tile > sim.log 2>&1 ||
   { echo "Simulation did not end cleanly, see sim.log"; exit 1; }
grep -q "TEST RESULT: FAIL" sim.log &&
   { echo "Simulation failed, see sim.log"; exit 1; } ||
   { echo "Simulation passed"; exit 0; }

//--- tests/na_patterns.txt
# op W or R: bus address, write data or expected read data; op I: expected irq_o in the value
# op N or O: last flag, flit injected on noc_in_i or expected on noc_out_o
R 00000000 00000005
R 00000004 00000040
R 00000008 00000000
W 0000000c 000000a6
R 0000000c 000000a6
W 00100000 00000003
W 00100000 28080010
W 00100000 cafe0001
W 00100000 cafe0002
O 0 28080010
O 0 cafe0001
O 1 cafe0002
N 0 2a080002
N 1 deadbeef
R 00100004 00000000
R 00000008 00000001
R 00100000 00000000
N 0 28080003
N 0 a0000001
N 0 a0000002
N 1 a0000003
R 00100004 00000001
I 0 0
W 0000000c 00000001
I 0 1
R 00100000 00000004
R 00100000 28080003
R 00100000 a0000001
R 00100000 a0000002
R 00100000 a0000003
R 00100004 00000000
I 0 0
R 00300000 00000000

//--- tests/tb_na_compute_tile.sv
`timescale 1ns/1ps

module tb_na_compute_tile;

   localparam int CYCLES_PER_LINE = 200;

   logic              clk;
   logic              reset;
   na_pkg::noc_link_t noc_in;
   logic              noc_in_valid;
   logic              noc_in_ready;
   na_pkg::noc_link_t noc_out;
   logic              noc_out_valid;
   logic              noc_out_ready;
   na_pkg::wb_req_t   wb_req;
   na_pkg::wb_rsp_t   wb_rsp;
   logic              irq;

   integer            seed;
   logic [31:0]       rnd;
   int                errors = 0;
   int                checks = 0;
   int                cycles = 0;
   int                cycle_limit = 0;

   logic [7:0]        op_q  [$];   // Operation letters
   logic [31:0]       arg_q [$];   // Address or last flag
   logic [31:0]       val_q [$];
   logic [32:0]       out_seen [$];   // {last, data} of each flit taken from the tile

   na_compute_tile #(
      .TILEID    (5),
      .COREBASE  ('h40),
      .BUF_DEPTH (4),
      .MP_DEPTH  (16)
   ) UUT (
      .clk             (clk),
      .reset_i         (reset),
      .noc_in_i        (noc_in),
      .noc_in_valid_i  (noc_in_valid),
      .noc_in_ready_o  (noc_in_ready),
      .noc_out_o       (noc_out),
      .noc_out_valid_o (noc_out_valid),
      .noc_out_ready_i (noc_out_ready),
      .wb_req_i        (wb_req),
      .wb_rsp_o        (wb_rsp),
      .irq_o           (irq)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Random back-pressure on the NoC output
   initial begin
      seed = 93538;
      noc_out_ready = 1'b0;
      forever begin
         @(negedge clk);
         rnd = $random(seed);
         noc_out_ready = rnd[0];
         if (noc_out_valid && noc_out_ready)   // Transfers on the next rising edge
            out_seen.push_back({noc_out.last, noc_out.flit.data});
      end
   end

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Error at %0d ns: %s is 0x%h, expected 0x%h", $time, name, actual, expected);
      end
   endtask

   // Outputs that reset holds low
   task automatic check_reset_state();
      check_value("noc_in_ready_o", {31'd0, noc_in_ready}, 32'd0);
      check_value("noc_out_valid_o", {31'd0, noc_out_valid}, 32'd0);
      check_value("wb_rsp_o.ack", {31'd0, wb_rsp.ack}, 32'd0);
      check_value("wb_rsp_o.err", {31'd0, wb_rsp.err}, 32'd0);
      check_value("irq_o", {31'd0, irq}, 32'd0);
   endtask

   // Regions 0 and 1 are the only slaves
   function automatic logic is_mapped(input logic [31:0] adr);
      return (adr[23:20] == 4'd0) || (adr[23:20] == 4'd1);
   endfunction

   task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                             output logic [31:0] rdata);
      int   waited;
      logic mapped;
      mapped = is_mapped(adr);
      @(negedge clk);
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.adr = adr;
      wb_req.dat = dat;
      waited = 1;
      @(negedge clk);
      while (!wb_rsp.ack && !wb_rsp.err) begin
         waited++;
         @(negedge clk);
      end
      check_value("bus response delay", waited, 1);
      check_value("wb_rsp_o.ack", {31'd0, wb_rsp.ack}, {31'd0, mapped});
      check_value("wb_rsp_o.err", {31'd0, wb_rsp.err}, {31'd0, !mapped});
      rdata = wb_rsp.dat;
      wb_req = '0;   // Idle for at least one cycle
   endtask

   task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat);
      logic [31:0] unused;
      bus_access(1'b1, adr, dat, unused);
   endtask

   task automatic bus_read_check(input logic [31:0] adr, input logic [31:0] expected);
      logic [31:0] rdata;
      bus_access(1'b0, adr, '0, rdata);
      if (is_mapped(adr))
         check_value("wb_rsp_o.dat", rdata, expected);
   endtask

   task automatic inject_flit(input logic last, input logic [31:0] data);
      @(negedge clk);
      noc_in.flit.data = data;
      noc_in.last      = last;
      noc_in_valid     = 1'b1;
      while (!noc_in_ready)
         @(negedge clk);
      @(negedge clk);   // Taken on the edge just passed
      noc_in_valid = 1'b0;
   endtask

   task automatic expect_flit(input logic last, input logic [31:0] data);
      logic [32:0] flit;
      @(posedge clk);
      while (out_seen.size() == 0)
         @(posedge clk);
      flit = out_seen.pop_front();
      check_value("noc_out_o.flit", flit[31:0], data);
      check_value("noc_out_o.last", {31'd0, flit[32]}, {31'd0, last});
   endtask

   task automatic check_irq(input logic expected);
      @(negedge clk);
      check_value("irq_o", {31'd0, irq}, {31'd0, expected});
   endtask

   task automatic load_patterns(output bit ok);
      int              fd;
      int              code;
      logic [63:0]     tok;
      logic [31:0]     arg;
      logic [31:0]     val;
      logic [8*128-1:0] rest;
      ok = 1'b0;
      fd = $fopen("tests/na_patterns.txt", "r");
      if (fd != 0) begin
         ok = 1'b1;
         code = $fscanf(fd, "%s", tok);
         while (code == 1) begin
            if (tok == "#") begin
               code = $fgets(rest, fd);   // Comment line
            end else begin
               code = $fscanf(fd, "%h %h", arg, val);
               if (code != 2) begin
                  $display("The pattern file has a line with missing columns");
                  ok = 1'b0;
               end
               op_q.push_back(tok[7:0]);
               arg_q.push_back(arg);
               val_q.push_back(val);
            end
            code = $fscanf(fd, "%s", tok);
         end
         $fclose(fd);
      end
   endtask

   initial begin
      bit ok;
      int i;
      reset        = 1'b1;
      wb_req       = '0;
      noc_in       = '0;
      noc_in_valid = 1'b0;
      load_patterns(ok);
      if (!ok) begin
         $display("Could not read the pattern file tests/na_patterns.txt");
         $display("TEST RESULT: FAIL");
         $finish;
      end else begin
         cycle_limit = CYCLES_PER_LINE * op_q.size();
         repeat (10) @(negedge clk);
         check_reset_state();
         reset = 1'b0;
         for (i = 0; i < op_q.size(); i++) begin
            case (op_q[i])
               "W": bus_write(arg_q[i], val_q[i]);
               "R": bus_read_check(arg_q[i], val_q[i]);
               "N": inject_flit(arg_q[i][0], val_q[i]);
               "O": expect_flit(arg_q[i][0], val_q[i]);
               "I": check_irq(val_q[i][0]);
               default: begin
                  errors++;
                  $display("The pattern file has an unknown operation %s", op_q[i]);
               end
            endcase
         end
         repeat (20) @(negedge clk);
         check_value("extra flits on noc_out_o", out_seen.size(), 0);
         $display("Checks run: %0d, errors: %0d", checks, errors);
         if (errors == 0)
            $display("TEST RESULT: PASS");
         else
            $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   // Budget grows with the number of pattern lines
   initial begin
      wait (cycle_limit != 0);
      while (cycles < cycle_limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

//--- verilog/na_compute_tile.sv
`timescale 1ns/1ps

module na_compute_tile #(
   parameter int TILEID    = 0,
   parameter int COREBASE  = 0,
   parameter int BUF_DEPTH = 4,
   parameter int MP_DEPTH  = 16
) (
   input  logic              clk,
   input  logic              reset_i,
   input  na_pkg::noc_link_t noc_in_i,
   input  logic              noc_in_valid_i,
   output logic              noc_in_ready_o,
   output na_pkg::noc_link_t noc_out_o,
   output logic              noc_out_valid_o,
   input  logic              noc_out_ready_i,
   input  na_pkg::wb_req_t   wb_req_i,
   output na_pkg::wb_rsp_t   wb_rsp_o,
   output logic              irq_o
);

   na_pkg::noc_link_t send_link;
   logic              send_valid;
   logic              send_ready;
   na_pkg::noc_link_t recv_link;
   logic              recv_valid;
   logic              recv_ready;
   na_pkg::slv_req_t  conf_req;
   na_pkg::slv_req_t  mp_req;
   na_pkg::slv_rsp_t  conf_rsp;
   na_pkg::slv_rsp_t  mp_rsp;
   logic              irq_en;
   logic              drop;
   logic              overflow;

   wb_slave_decode u_decode (
      .clk        (clk),
      .reset_i    (reset_i),
      .wb_req_i   (wb_req_i),
      .wb_rsp_o   (wb_rsp_o),
      .conf_req_o (conf_req),
      .mp_req_o   (mp_req),
      .conf_rsp_i (conf_rsp),
      .mp_rsp_i   (mp_rsp)
   );

   na_conf #(
      .TILEID   (TILEID),
      .COREBASE (COREBASE)
   ) u_conf (
      .clk      (clk),
      .reset_i  (reset_i),
      .req_i    (conf_req),
      .rsp_o    (conf_rsp),
      .drop_i   (drop),
      .irq_en_o (irq_en)
   );

   // Send path
   mp_send #(
      .DEPTH(MP_DEPTH)
   ) u_send (
      .clk         (clk),
      .reset_i     (reset_i),
      .req_i       (mp_req),
      .out_o       (send_link),
      .out_valid_o (send_valid),
      .out_ready_i (send_ready),
      .overflow_o  (overflow)
   );

   noc_flit_fifo #(
      .DEPTH(BUF_DEPTH)
   ) u_outbuffer (
      .clk         (clk),
      .reset_i     (reset_i),
      .in_i        (send_link),
      .in_valid_i  (send_valid),
      .in_ready_o  (send_ready),
      .out_o       (noc_out_o),
      .out_valid_o (noc_out_valid_o),
      .out_ready_i (noc_out_ready_i)
   );

   // Receive path
   noc_flit_fifo #(
      .DEPTH(BUF_DEPTH)
   ) u_inbuffer (
      .clk         (clk),
      .reset_i     (reset_i),
      .in_i        (noc_in_i),
      .in_valid_i  (noc_in_valid_i),
      .in_ready_o  (noc_in_ready_o),
      .out_o       (recv_link),
      .out_valid_o (recv_valid),
      .out_ready_i (recv_ready)
   );

   mp_recv #(
      .DEPTH(MP_DEPTH)
   ) u_recv (
      .clk        (clk),
      .reset_i    (reset_i),
      .in_i       (recv_link),
      .in_valid_i (recv_valid),
      .in_ready_o (recv_ready),
      .req_i      (mp_req),
      .rsp_o      (mp_rsp),
      .overflow_i (overflow),
      .irq_en_i   (irq_en),
      .drop_o     (drop),
      .irq_o      (irq_o)
   );

endmodule

//--- verilog/na_conf.sv
`timescale 1ns/1ps

module na_conf #(
   parameter int TILEID   = 0,
   parameter int COREBASE = 0
) (
   input  logic             clk,
   input  logic             reset_i,
   input  na_pkg::slv_req_t req_i,
   output na_pkg::slv_rsp_t rsp_o,
   input  logic             drop_i,
   output logic             irq_en_o
);

   logic [5:0]                   addr;
   logic [na_pkg::BUS_WIDTH-1:0] ctrl_q;
   logic [na_pkg::BUS_WIDTH-1:0] dropped_q;

   assign addr = {req_i.offset, 2'b00};   // Byte offset

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ctrl_q    <= '0;
         dropped_q <= '0;
      end else begin
         // Only the control register is writable
         if (req_i.stb && req_i.we && addr == na_pkg::CONF_CTRL)
            ctrl_q <= req_i.dat;
         if (drop_i)
            dropped_q <= dropped_q + 1'b1;   // One per discarded packet
      end
   end

   always_comb begin
      case (addr)
         na_pkg::CONF_TILEID:   rsp_o = na_pkg::slv_rsp_t'(TILEID);
         na_pkg::CONF_COREBASE: rsp_o = na_pkg::slv_rsp_t'(COREBASE);
         na_pkg::CONF_DROPPED:  rsp_o = dropped_q;
         na_pkg::CONF_CTRL:     rsp_o = ctrl_q;
         default:               rsp_o = '0;
      endcase
   end

   assign irq_en_o = ctrl_q[0];

endmodule

//--- verilog/noc_flit_fifo.sv
`timescale 1ns/1ps

module noc_flit_fifo #(
   parameter int DEPTH = 4
) (
   input  logic              clk,
   input  logic              reset_i,
   input  na_pkg::noc_link_t in_i,
   input  logic              in_valid_i,
   output logic              in_ready_o,
   output na_pkg::noc_link_t out_o,
   output logic              out_valid_o,
   input  logic              out_ready_i
);

   localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   na_pkg::noc_link_t mem [0:DEPTH-1];
   logic [PW-1:0]     wr_ptr;
   logic [PW-1:0]     rd_ptr;
   logic [CW-1:0]     count;
   logic [CW-1:0]     count_next;
   logic              wr;
   logic              rd;

   assign wr = in_valid_i & in_ready_o;
   assign rd = out_valid_o & out_ready_i;
   assign count_next = count + CW'(wr) - CW'(rd);

   assign out_o       = mem[rd_ptr];   // Head of queue
   assign out_valid_o = (count != '0);

   always_ff @(posedge clk) begin
      if (wr)
         mem[wr_ptr] <= in_i;
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         in_ready_o <= 1'b0;   // Opens the cycle after reset
      end else begin
         if (wr)
            wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (rd)
            rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         count      <= count_next;
         in_ready_o <= (count_next != CW'(DEPTH));   // Registered not-full
      end
   end

   // Registered ready must never let a flit into a full queue
   a_no_write_full: assert property (@(posedge clk) disable iff (reset_i)
      wr |-> count != CW'(DEPTH));

   // Pointers and count agree whenever the head is taken
   a_no_read_empty: assert property (@(posedge clk) disable iff (reset_i)
      rd |-> count != '0 && (rd_ptr != wr_ptr || count == CW'(DEPTH)));

endmodule

//--- verilog/wb_slave_decode.sv
`timescale 1ns/1ps

module wb_slave_decode (
   input  logic             clk,
   input  logic             reset_i,
   input  na_pkg::wb_req_t  wb_req_i,
   output na_pkg::wb_rsp_t  wb_rsp_o,
   output na_pkg::slv_req_t conf_req_o,
   output na_pkg::slv_req_t mp_req_o,
   input  na_pkg::slv_rsp_t conf_rsp_i,
   input  na_pkg::slv_rsp_t mp_rsp_i
);

   logic [3:0]       region;
   logic             start;
   logic             hit_conf;
   logic             hit_mp;
   logic             ack_q;
   logic             err_q;
   na_pkg::slv_req_t base;
   na_pkg::slv_rsp_t rdata;
   na_pkg::slv_rsp_t rdata_q;

   assign region   = wb_req_i.adr[23:20];
   assign hit_conf = (region == na_pkg::REGION_CONF);
   assign hit_mp   = (region == na_pkg::REGION_MP);

   // Master still holds stb during the response cycle
   assign start = wb_req_i.cyc & wb_req_i.stb & ~ack_q & ~err_q;

   always_comb begin
      base.stb    = start;
      base.we     = wb_req_i.we;
      base.offset = wb_req_i.adr[5:2];
      base.dat    = wb_req_i.dat;

      conf_req_o     = base;
      conf_req_o.stb = start & hit_conf;
      mp_req_o       = base;
      mp_req_o.stb   = start & hit_mp;
   end

   always_comb begin
      case (region)
         na_pkg::REGION_CONF: rdata = conf_rsp_i;
         na_pkg::REGION_MP:   rdata = mp_rsp_i;
         default:             rdata = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= start & (hit_conf | hit_mp);
         err_q <= start & ~(hit_conf | hit_mp);   // Unmapped region
      end
   end

   // Captured together with the slave's action
   always_ff @(posedge clk) begin
      if (start)
         rdata_q <= rdata;
   end

   always_comb begin
      wb_rsp_o.ack = ack_q;
      wb_rsp_o.err = err_q;
      wb_rsp_o.dat = rdata_q;
   end

   a_ack_err_excl: assert property (@(posedge clk) disable iff (reset_i)
      !(wb_rsp_o.ack && wb_rsp_o.err));

endmodule
